/* compile.f */
source/mem_sched_pkg.sv
source/tile_iter_counter.sv
source/x_addr_gen.sv
source/dequant_bias.sv
source/mem_sched_top.sv
dv/mem_sched_props.sv
dv/mem_sched_checker.sv
dv/tb_mem_sched.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal -j 0
TOP       := tb_mem_sched
FILELIST  := compile.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := Checks failed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* dv/tb_mem_sched.sv */
// Memory scheduler testbench
// Runs a table of tiling walks with random bias stream traffic and
// ready drops, with the checker comparing the DUT against its model

`timescale 1ns/1ns
`default_nettype none

module tb_mem_sched;

  localparam int unsigned ArrayW   = mem_sched_pkg::ARRAY_W;
  localparam int unsigned ColStep  = mem_sched_pkg::COL_STEP;
  localparam int unsigned GidW     = mem_sched_pkg::GID_W;
  localparam int          NumTests = 4;

  // One walk, ready_mask bits mark streams whose ready may drop {wq, zeros, scales}
  typedef struct packed {
    mem_sched_pkg::tile_cfg_t    tile;
    mem_sched_pkg::dequant_cfg_t deq;
    logic [7:0]                  pulses;
    logic [2:0]                  ready_mask;
    logic [31:0]                 end_addr;
    logic [7:0]                  end_len;
  } test_row_t;

  string test_names [NumTests] = '{"full_walk_q8", "partial_q4", "last_row_q2", "zero_leftover"};

  // Expected end address and length worked out by hand from the walk rules
  test_row_t tests [NumTests] = '{
    '{'{32'h1000, 32'h400, 16'd3, 16'd2, 16'd2, 8'd5, 16'd12},
      '{mem_sched_pkg::QINT_8, 16'h0100}, 8'd12, 3'b000, 32'h1000, 8'd8},
    '{'{32'h2000, 32'h100, 16'd4, 16'd2, 16'd3, 8'd3, 16'd24},
      '{mem_sched_pkg::QINT_4, 16'h0060}, 8'd10, 3'b111, 32'h2140, 8'd8},
    '{'{32'h8000, 32'h200, 16'd2, 16'd1, 16'd2, 8'd6, 16'd4},
      '{mem_sched_pkg::QINT_2, 16'h0048}, 8'd3, 3'b101, 32'h8220, 8'd6},
    '{'{32'h0040, 32'h080, 16'd1, 16'd3, 16'd2, 8'd0, 16'd6},
      '{mem_sched_pkg::QINT_8, 16'h0003}, 8'd5, 3'b010, 32'h00c0, 8'd8}
  };

  logic                        clk_i = 1'b0;
  logic                        rst_ni;
  logic                        clear_i;
  logic                        restart_i;
  logic                        first_load_i;
  logic                        idle_i;
  logic                        x_done_i;
  logic                        x_ready_start_i;
  mem_sched_pkg::tile_cfg_t    tile_cfg_i;
  mem_sched_pkg::dequant_cfg_t dequant_cfg_i;
  logic                        gidx_valid_i;
  mem_sched_pkg::gidx_beat_t   gidx_i;
  logic                        scales_ready_i;
  logic                        zeros_ready_i;
  logic                        row_valid_i;
  logic [15:0]                 row_i;
  logic                        wq_ready_i;
  mem_sched_pkg::x_req_t       x_req;
  logic                        gidx_ready;
  logic                        scales_valid;
  mem_sched_pkg::bias_beat_t   scales;
  logic                        zeros_valid;
  mem_sched_pkg::bias_beat_t   zeros;
  logic                        row_ready;
  logic                        wq_valid;
  mem_sched_pkg::bias_beat_t   wq;
  int unsigned                 cycle_cnt = 0;
  int unsigned                 cycle_limit;

  always #2 clk_i = ~clk_i;

  mem_sched_top #(
    .ARRAY_W (ArrayW),
    .COL_STEP(ColStep),
    .GID_W   (GidW)
  ) i_mem_sched_top (
    .x_req_o       (x_req),
    .gidx_ready_o  (gidx_ready),
    .scales_valid_o(scales_valid),
    .scales_o      (scales),
    .zeros_valid_o (zeros_valid),
    .zeros_o       (zeros),
    .row_ready_o   (row_ready),
    .wq_valid_o    (wq_valid),
    .wq_o          (wq),
    .*
  );

  mem_sched_checker #(
    .ARRAY_W (ArrayW),
    .COL_STEP(ColStep)
  ) i_mem_sched_checker (
    .x_req_i       (x_req),
    .gidx_ready_i  (gidx_ready),
    .scales_valid_i(scales_valid),
    .scales_i      (scales),
    .zeros_valid_i (zeros_valid),
    .zeros_i       (zeros),
    .row_ready_i   (row_ready),
    .wq_valid_i    (wq_valid),
    .wq_i          (wq),
    .*
  );

  bind mem_sched_top mem_sched_props i_mem_sched_props (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .restart_i     (restart_i),
    .first_load_i  (first_load_i),
    .req_start_i   (req_start),
    .gidx_ready_i  (gidx_ready_o),
    .scales_valid_i(scales_valid_o),
    .scales_ready_i(scales_ready_i),
    .zeros_valid_i (zeros_valid_o),
    .zeros_ready_i (zeros_ready_i),
    .wq_valid_i    (wq_valid_o),
    .wq_ready_i    (wq_ready_i)
  );

  function automatic int unsigned cycle_budget();
    int unsigned sum = 0;
    for (int t = 0; t < NumTests; t++) begin
      sum += tests[t].pulses;
    end
    return 4 * sum + 200;
  endfunction

  // Random beats, ready drops and phase levels for one cycle
  task automatic drive_beats(input logic [2:0] mask);
    gidx_valid_i    = 1'($urandom);
    gidx_i.idx      = GidW'($urandom);
    gidx_i.skip     = 1'($urandom);
    row_valid_i     = 1'($urandom);
    row_i           = 16'($urandom % 1024);
    scales_ready_i  = !(mask[0] && ($urandom % 3 == 0));
    zeros_ready_i   = !(mask[1] && ($urandom % 3 == 0));
    wq_ready_i      = !(mask[2] && ($urandom % 3 == 0));
    first_load_i    = ($urandom % 4 == 0);
    idle_i          = ($urandom % 4 == 0);
    x_ready_start_i = ($urandom % 4 != 0);
  endtask

  task automatic run_test(input int t);
    tile_cfg_i    = tests[t].tile;
    dequant_cfg_i = tests[t].deq;
    restart_i     = 1'b1;
    @(posedge clk_i);
    #1;
    restart_i = 1'b0;
    i_mem_sched_checker.start_test(test_names[t]);
    i_mem_sched_checker.compare("restart base_addr", tests[t].tile.x_addr, x_req.base_addr);
    i_mem_sched_checker.compare("restart tot_len", 32'(ArrayW), 32'(x_req.tot_len));
    for (int p = 0; p < int'(tests[t].pulses); p++) begin
      drive_beats(tests[t].ready_mask);
      x_done_i = 1'b1;
      @(posedge clk_i);
      #1;
      x_done_i = 1'b0;
      drive_beats(tests[t].ready_mask);
      @(posedge clk_i);
      #1;
    end
    i_mem_sched_checker.compare("end base_addr", tests[t].end_addr, x_req.base_addr);
    i_mem_sched_checker.compare("end tot_len", 32'(tests[t].end_len), 32'(x_req.tot_len));
    i_mem_sched_checker.finish_test();
  endtask

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= cycle_limit) begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("Checks failed");
      $finish;
    end
  end

  initial begin
    void'($urandom(29034));
    cycle_limit     = cycle_budget();
    rst_ni          = 1'b0;
    clear_i         = 1'b0;
    restart_i       = 1'b0;
    first_load_i    = 1'b0;
    idle_i          = 1'b1;
    x_done_i        = 1'b0;
    x_ready_start_i = 1'b0;
    tile_cfg_i      = '0;
    dequant_cfg_i   = '0;
    gidx_valid_i    = 1'b0;
    gidx_i          = '0;
    scales_ready_i  = 1'b1;
    zeros_ready_i   = 1'b1;
    row_valid_i     = 1'b0;
    row_i           = '0;
    wq_ready_i      = 1'b1;
    repeat (2) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    for (int t = 0; t < NumTests; t++) begin
      run_test(t);
    end
    $display("%0d tests, %0d checks, %0d errors, %0d assertion failures", NumTests,
             i_mem_sched_checker.check_cnt, i_mem_sched_checker.err_cnt,
             i_mem_sched_top.i_mem_sched_props.fail_cnt);
    if (i_mem_sched_checker.err_cnt == 0 &&
        i_mem_sched_top.i_mem_sched_props.fail_cnt == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* dv/mem_sched_checker.sv */
// Memory scheduler checker
// Reference model of the tiling walk, X address and dequantization bias,
// compared against the DUT ports every cycle, with per-test summaries

`timescale 1ns/1ns
`default_nettype none

module mem_sched_checker #(
  parameter int unsigned ARRAY_W  = mem_sched_pkg::ARRAY_W,
  parameter int unsigned COL_STEP = mem_sched_pkg::COL_STEP
) (
  input logic                             clk_i,
  input logic                             rst_ni,
  input logic                             clear_i,
  input logic                             restart_i,
  input logic                             first_load_i,
  input logic                             idle_i,
  input logic                             x_done_i,
  input logic                             x_ready_start_i,
  input mem_sched_pkg::tile_cfg_t         tile_cfg_i,
  input mem_sched_pkg::dequant_cfg_t      dequant_cfg_i,
  input mem_sched_pkg::x_req_t            x_req_i,
  input logic                             gidx_valid_i,
  input mem_sched_pkg::gidx_beat_t        gidx_i,
  input logic                             gidx_ready_i,
  input logic                             scales_valid_i,
  input mem_sched_pkg::bias_beat_t        scales_i,
  input logic                             scales_ready_i,
  input logic                             zeros_valid_i,
  input mem_sched_pkg::bias_beat_t        zeros_i,
  input logic                             zeros_ready_i,
  input logic                             row_valid_i,
  input logic [mem_sched_pkg::ITER_W-1:0] row_i,
  input logic                             row_ready_i,
  input logic                             wq_valid_i,
  input mem_sched_pkg::bias_beat_t        wq_i,
  input logic                             wq_ready_i
);

  logic [15:0] col_m;
  logic [15:0] w_m;
  logic [15:0] row_m;
  logic [15:0] tot_m;
  string       test_name = "none";
  bit          active = 1'b0;
  int unsigned check_cnt = 0;
  int unsigned err_cnt = 0;
  int unsigned test_checks = 0;
  int unsigned test_errs = 0;

  function automatic int fmt_shift(input mem_sched_pkg::qint_fmt_e fmt);
    case (fmt)
      mem_sched_pkg::QINT_8: return 1;
      mem_sched_pkg::QINT_4: return 2;
      mem_sched_pkg::QINT_2: return 3;
      default:               return 0;
    endcase
  endfunction

  task automatic compare(input string what, input logic [31:0] exp_v, input logic [31:0] act_v);
    check_cnt++;
    test_checks++;
    if (exp_v !== act_v) begin
      err_cnt++;
      test_errs++;
      $display("error %s %s: expected %h actual %h", test_name, what, exp_v, act_v);
    end
  endtask

  task automatic start_test(input string name);
    test_name   = name;
    test_checks = 0;
    test_errs   = 0;
    active      = 1'b1;
  endtask

  task automatic finish_test();
    $display("test %s: %0d checks, %0d errors", test_name, test_checks, test_errs);
    active = 1'b0;
  endtask

  // Walk model, columns innermost and rows outermost
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni || clear_i || restart_i) begin
      col_m <= '0;
      w_m   <= '0;
      row_m <= '0;
      tot_m <= '0;
    end else if (x_done_i) begin
      tot_m <= tot_m + 16'd1;
      if (32'(col_m) + 1 < 32'(tile_cfg_i.x_col_iters)) begin
        col_m <= col_m + 16'd1;
      end else begin
        col_m <= '0;
        if (32'(w_m) + 1 < 32'(tile_cfg_i.w_iters)) begin
          w_m <= w_m + 16'd1;
        end else begin
          w_m   <= '0;
          row_m <= (32'(row_m) + 1 < 32'(tile_cfg_i.x_row_iters)) ? row_m + 16'd1 : '0;
        end
      end
    end
  end

  // Mid-cycle compare, inputs change just after the rising edge
  always @(negedge clk_i) begin
    logic [31:0] exp_base;
    logic [7:0]  exp_len;
    logic        exp_req;
    logic        g_rdy;
    logic [31:0] stride_n;
    exp_base = tile_cfg_i.x_addr + 32'(row_m) * tile_cfg_i.x_row_offs + 32'(col_m) * COL_STEP;
    exp_len  = (32'(row_m) + 1 == 32'(tile_cfg_i.x_row_iters) && tile_cfg_i.leftover_rows != 0)
               ? tile_cfg_i.leftover_rows : 8'(ARRAY_W);
    exp_req  = !idle_i && x_ready_start_i &&
               (first_load_i || (tot_m != 0 && tot_m != tile_cfg_i.tot_x_read));
    g_rdy    = scales_ready_i && zeros_ready_i;
    stride_n = 32'(dequant_cfg_i.w_stride) >> fmt_shift(dequant_cfg_i.fmt);
    if (rst_ni && active) begin
      compare("base_addr", exp_base, x_req_i.base_addr);
      compare("tot_len", 32'(exp_len), 32'(x_req_i.tot_len));
      compare("req_start", 32'(exp_req), 32'(x_req_i.req_start));
      compare("gidx_ready", 32'(g_rdy), 32'(gidx_ready_i));
      compare("scales_valid", 32'(gidx_valid_i && g_rdy), 32'(scales_valid_i));
      compare("zeros_valid", 32'(gidx_valid_i && g_rdy), 32'(zeros_valid_i));
      compare("row_ready", 32'(wq_ready_i), 32'(row_ready_i));
      compare("wq_valid", 32'(row_valid_i && wq_ready_i), 32'(wq_valid_i));
      if (gidx_valid_i && g_rdy) begin
        compare("scales bias", 32'(gidx_i.idx) * 32'(dequant_cfg_i.w_stride), scales_i.bias);
        compare("zeros bias", 32'(gidx_i.idx) * stride_n, zeros_i.bias);
        compare("scales skip", 32'(gidx_i.skip), 32'(scales_i.skip));
        compare("zeros skip", 32'(gidx_i.skip), 32'(zeros_i.skip));
      end
      if (row_valid_i && wq_ready_i) begin
        compare("wq bias", 32'(row_i) * stride_n, wq_i.bias);
        // Row beats carry no group skip
        compare("wq skip", 32'd0, 32'(wq_i.skip));
      end
    end
  end

endmodule

`default_nettype wire

/* dv/mem_sched_props.sv */
// Memory scheduler assertions
// Stream handshake rules of the bias streams and the X start request
// gating right after a scheduler restart

`timescale 1ns/1ns
`default_nettype none

module mem_sched_props (
  input logic clk_i,
  input logic rst_ni,
  input logic restart_i,
  input logic first_load_i,
  input logic req_start_i,
  input logic gidx_ready_i,
  input logic scales_valid_i,
  input logic scales_ready_i,
  input logic zeros_valid_i,
  input logic zeros_ready_i,
  input logic wq_valid_i,
  input logic wq_ready_i
);

  int unsigned fail_cnt = 0;

  a_scales_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    scales_valid_i |-> scales_ready_i)
  else begin
    $error("scales valid while not ready");
    fail_cnt++;
  end

  a_zeros_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    zeros_valid_i |-> zeros_ready_i)
  else begin
    $error("zeros valid while not ready");
    fail_cnt++;
  end

  a_wq_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wq_valid_i |-> wq_ready_i)
  else begin
    $error("wq valid while not ready");
    fail_cnt++;
  end

  a_gidx_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
    gidx_ready_i |-> (scales_ready_i && zeros_ready_i))
  else begin
    $error("group ready without both output readies");
    fail_cnt++;
  end

  // Total count is zero after a restart, only the first load can start X
  a_restart_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    restart_i |=> (!req_start_i || first_load_i))
  else begin
    $error("X start request after restart without first load");
    fail_cnt++;
  end

endmodule

`default_nettype wire

/* source/mem_sched_top.sv */
// Memory scheduler, X tiling and dequantization bias
// Ties the tile iteration counter to the X address generator and runs
// the bias streams for scales, zero points and packed weights alongside

`timescale 1ns/1ns
`default_nettype none

module mem_sched_top #(
  parameter int unsigned ARRAY_W  = mem_sched_pkg::ARRAY_W,
  parameter int unsigned COL_STEP = mem_sched_pkg::COL_STEP,
  parameter int unsigned GID_W    = mem_sched_pkg::GID_W
) (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             clear_i,
  input  logic                             restart_i,
  input  logic                             first_load_i,
  input  logic                             idle_i,
  input  logic                             x_done_i,
  input  logic                             x_ready_start_i,
  input  mem_sched_pkg::tile_cfg_t         tile_cfg_i,
  input  mem_sched_pkg::dequant_cfg_t      dequant_cfg_i,
  output mem_sched_pkg::x_req_t            x_req_o,
  input  logic                             gidx_valid_i,
  input  mem_sched_pkg::gidx_beat_t        gidx_i,
  output logic                             gidx_ready_o,
  output logic                             scales_valid_o,
  output mem_sched_pkg::bias_beat_t        scales_o,
  input  logic                             scales_ready_i,
  output logic                             zeros_valid_o,
  output mem_sched_pkg::bias_beat_t        zeros_o,
  input  logic                             zeros_ready_i,
  input  logic                             row_valid_i,
  input  logic [mem_sched_pkg::ITER_W-1:0] row_i,
  output logic                             row_ready_o,
  output logic                             wq_valid_o,
  output mem_sched_pkg::bias_beat_t        wq_o,
  input  logic                             wq_ready_i
);

  mem_sched_pkg::tile_pos_t tile_pos;
  logic                     req_start;

  tile_iter_counter i_tile_iter_counter (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .clear_i        (clear_i),
    .restart_i      (restart_i),
    .first_load_i   (first_load_i),
    .idle_i         (idle_i),
    .x_done_i       (x_done_i),
    .x_ready_start_i(x_ready_start_i),
    .cfg_i          (tile_cfg_i),
    .pos_o          (tile_pos),
    .req_start_o    (req_start)
  );

  x_addr_gen #(
    .ARRAY_W (ARRAY_W),
    .COL_STEP(COL_STEP)
  ) i_x_addr_gen (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .clear_i    (clear_i),
    .restart_i  (restart_i),
    .cfg_i      (tile_cfg_i),
    .pos_i      (tile_pos),
    .req_start_i(req_start),
    .x_req_o    (x_req_o)
  );

  dequant_bias #(
    .GID_W(GID_W)
  ) i_dequant_bias (
    .cfg_i         (dequant_cfg_i),
    .gidx_valid_i  (gidx_valid_i),
    .gidx_i        (gidx_i),
    .gidx_ready_o  (gidx_ready_o),
    .scales_valid_o(scales_valid_o),
    .scales_o      (scales_o),
    .scales_ready_i(scales_ready_i),
    .zeros_valid_o (zeros_valid_o),
    .zeros_o       (zeros_o),
    .zeros_ready_i (zeros_ready_i),
    .row_valid_i   (row_valid_i),
    .row_i         (row_i),
    .row_ready_o   (row_ready_o),
    .wq_valid_o    (wq_valid_o),
    .wq_o          (wq_o),
    .wq_ready_i    (wq_ready_i)
  );

endmodule

`default_nettype wire

/* source/dequant_bias.sv */
// Dequantization bias
// Turns group indices into scale and zero-point byte offsets and row
// indices into packed-weight byte offsets, with the stride shift set by
// the integer format. Fully combinational valid/ready joins

`timescale 1ns/1ns
`default_nettype none

module dequant_bias #(
  parameter int unsigned GID_W = mem_sched_pkg::GID_W
) (
  input  mem_sched_pkg::dequant_cfg_t           cfg_i,
  input  logic                                  gidx_valid_i,
  input  mem_sched_pkg::gidx_beat_t             gidx_i,
  output logic                                  gidx_ready_o,
  output logic                                  scales_valid_o,
  output mem_sched_pkg::bias_beat_t             scales_o,
  input  logic                                  scales_ready_i,
  output logic                                  zeros_valid_o,
  output mem_sched_pkg::bias_beat_t             zeros_o,
  input  logic                                  zeros_ready_i,
  input  logic                                  row_valid_i,
  input  logic [mem_sched_pkg::ITER_W-1:0]      row_i,
  output logic                                  row_ready_o,
  output logic                                  wq_valid_o,
  output mem_sched_pkg::bias_beat_t             wq_o,
  input  logic                                  wq_ready_i
);

  localparam int unsigned AddrW = mem_sched_pkg::ADDR_W;
  localparam int unsigned GidProdW = GID_W + 16;
  localparam int unsigned RowProdW = mem_sched_pkg::ITER_W + 16;

  logic [1:0]          q_shift;
  logic [15:0]         stride_q;
  logic [GidProdW-1:0] scales_prod;
  logic [GidProdW-1:0] zeros_prod;
  logic [RowProdW-1:0] wq_prod;

  // Fewer bits per weight means a narrower packed row
  always_comb begin
    case (cfg_i.fmt)
      mem_sched_pkg::QINT_4: q_shift = 2'd2;
      mem_sched_pkg::QINT_2: q_shift = 2'd3;
      default:               q_shift = 2'd1;
    endcase
  end

  assign stride_q = cfg_i.w_stride >> q_shift;

  assign scales_prod = gidx_i.idx * cfg_i.w_stride;
  assign zeros_prod  = gidx_i.idx * stride_q;
  assign wq_prod     = row_i * stride_q;

  // Scales and zeros leave together, so the group beat waits for both
  assign gidx_ready_o   = scales_ready_i && zeros_ready_i;
  assign scales_valid_o = gidx_valid_i && gidx_ready_o;
  assign zeros_valid_o  = gidx_valid_i && gidx_ready_o;

  assign scales_o.bias = AddrW'(scales_prod);
  assign scales_o.skip = gidx_i.skip;
  assign zeros_o.bias  = AddrW'(zeros_prod);
  assign zeros_o.skip  = gidx_i.skip;

  assign row_ready_o = wq_ready_i;
  assign wq_valid_o  = row_valid_i && wq_ready_i;
  assign wq_o.bias   = AddrW'(wq_prod);
  assign wq_o.skip   = 1'b0;

endmodule

`default_nettype wire

/* source/x_addr_gen.sv */
// X address generator
// Accumulates column and row byte offsets along the tiling walk and builds
// the X start address and read length for the X stream source

`timescale 1ns/1ns
`default_nettype none

module x_addr_gen #(
  parameter int unsigned ARRAY_W  = mem_sched_pkg::ARRAY_W,
  parameter int unsigned COL_STEP = mem_sched_pkg::COL_STEP
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     clear_i,
  input  logic                     restart_i,
  input  mem_sched_pkg::tile_cfg_t cfg_i,
  input  mem_sched_pkg::tile_pos_t pos_i,
  input  logic                     req_start_i,
  output mem_sched_pkg::x_req_t    x_req_o
);

  localparam int unsigned AddrW = mem_sched_pkg::ADDR_W;

  logic [AddrW-1:0] col_offs_q;
  logic [AddrW-1:0] row_offs_q;
  logic             use_leftover;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      col_offs_q <= '0;
      row_offs_q <= '0;
    end else if (clear_i || restart_i) begin
      col_offs_q <= '0;
      row_offs_q <= '0;
    end else if (pos_i.step) begin
      col_offs_q <= pos_i.col_last ? '0 : col_offs_q + AddrW'(COL_STEP);
      // Next row tile once all W tiles of this row are done
      if (pos_i.col_last && pos_i.w_last) begin
        row_offs_q <= pos_i.row_last ? '0 : row_offs_q + cfg_i.x_row_offs;
      end
    end
  end

  // Last row may be only partly filled
  assign use_leftover = pos_i.row_last && (cfg_i.leftover_rows != '0);

  assign x_req_o.base_addr = cfg_i.x_addr + row_offs_q + col_offs_q;
  assign x_req_o.tot_len   = use_leftover ? cfg_i.leftover_rows : 8'(ARRAY_W);
  assign x_req_o.req_start = req_start_i;

endmodule

`default_nettype wire

/* source/tile_iter_counter.sv */
// X tile iteration counter
// Walks X columns, W tiles and X rows as nested counters, one step per
// finished X tile, keeps the total tile count and raises the X start request

`timescale 1ns/1ns
`default_nettype none

module tile_iter_counter (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    clear_i,
  input  logic                    restart_i,
  input  logic                    first_load_i,
  input  logic                    idle_i,
  input  logic                    x_done_i,
  input  logic                    x_ready_start_i,
  input  mem_sched_pkg::tile_cfg_t cfg_i,
  output mem_sched_pkg::tile_pos_t pos_o,
  output logic                    req_start_o
);

  localparam int unsigned IterW = mem_sched_pkg::ITER_W;

  logic [IterW-1:0] col_q;
  logic [IterW-1:0] w_q;
  logic [IterW-1:0] row_q;
  logic [IterW-1:0] tot_q;

  logic col_last;
  logic w_last;
  logic row_last;
  logic tot_active;

  assign col_last = col_q == cfg_i.x_col_iters - IterW'(1);
  assign w_last   = w_q == cfg_i.w_iters - IterW'(1);
  assign row_last = row_q == cfg_i.x_row_iters - IterW'(1);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      col_q <= '0;
      w_q   <= '0;
      row_q <= '0;
      tot_q <= '0;
    end else if (clear_i || restart_i) begin
      col_q <= '0;
      w_q   <= '0;
      row_q <= '0;
      tot_q <= '0;
    end else if (x_done_i) begin
      col_q <= col_last ? '0 : col_q + IterW'(1);
      // W tiles advance once per full column sweep
      if (col_last) begin
        w_q <= w_last ? '0 : w_q + IterW'(1);
      end
      if (col_last && w_last) begin
        row_q <= row_last ? '0 : row_q + IterW'(1);
      end
      tot_q <= tot_q + IterW'(1);
    end
  end

  assign pos_o.col_last = col_last;
  assign pos_o.w_last   = w_last;
  assign pos_o.row_last = row_last;
  assign pos_o.step     = x_done_i;

  // Job in flight but not yet finished
  assign tot_active = (tot_q != '0) && (tot_q != cfg_i.tot_x_read);

  assign req_start_o = !idle_i && x_ready_start_i && (first_load_i || tot_active);

endmodule

`default_nettype wire

/* source/mem_sched_pkg.sv */
// Memory scheduler package
// Quantization format opcode, job configuration and stream beat types
// shared by the X tiling walk and the dequantization bias logic

`default_nettype none

package mem_sched_pkg;

  parameter int unsigned ARRAY_W  = 8;
  parameter int unsigned GID_W    = 8;
  parameter int unsigned COL_STEP = 32;
  parameter int unsigned ADDR_W   = 32;
  parameter int unsigned ITER_W   = 16;

  // Packed weight format, selects the stride shift
  typedef enum logic [1:0] {
    QINT_8 = 2'd0,
    QINT_4 = 2'd1,
    QINT_2 = 2'd2
  } qint_fmt_e;

  typedef struct packed {
    logic [ADDR_W-1:0] x_addr;
    logic [ADDR_W-1:0] x_row_offs;
    logic [ITER_W-1:0] x_col_iters;
    logic [ITER_W-1:0] w_iters;
    logic [ITER_W-1:0] x_row_iters;
    logic [7:0]        leftover_rows;
    logic [ITER_W-1:0] tot_x_read;
  } tile_cfg_t;

  typedef struct packed {
    qint_fmt_e   fmt;
    logic [15:0] w_stride;
  } dequant_cfg_t;

  typedef struct packed {
    logic col_last;
    logic w_last;
    logic row_last;
    logic step;
  } tile_pos_t;

  typedef struct packed {
    logic [ADDR_W-1:0] base_addr;
    logic [7:0]        tot_len;
    logic              req_start;
  } x_req_t;

  typedef struct packed {
    logic [GID_W-1:0] idx;
    logic             skip;
  } gidx_beat_t;

  typedef struct packed {
    logic [ADDR_W-1:0] bias;
    logic              skip;
  } bias_beat_t;

endpackage

`default_nettype wire
